/* rtl/cluster_periph_defines.svh */
/*
 * Core count, bus widths, unit select codes, register offsets
 * and reset values of the cluster peripheral block
 */
`ifndef CLUSTER_PERIPH_DEFINES_SVH
`define CLUSTER_PERIPH_DEFINES_SVH

`define NB_CORES        4
`define ADDR_W          12
`define DATA_W          32
`define NB_EVT          4
`define EVT_ID_W        2
`define UNIT_SEL_LSB    10

// Event vector bit positions
// Bit 3 is reserved and stays zero
`define EVT_TIMER       0
`define EVT_MAILBOX     1
`define EVT_SW          2

// Unit select codes on address bits 11:10
// Code 3 is unmapped
`define UNIT_CTRL       2'd0
`define UNIT_TIMER      2'd1
`define UNIT_EVENT      2'd2

`define CTRL_EOC        10'h000
`define CTRL_FETCH_EN   10'h008
`define CTRL_BOOT_BASE  10'h040

`define TIMER_CFG       10'h000
`define TIMER_COUNT     10'h004
`define TIMER_CMP       10'h008

`define EU_CORE_STRIDE  10'h010
`define EU_MASK         10'h000
`define EU_BUFFER       10'h004
`define EU_CLEAR        10'h008
`define EU_SW_EVT       10'h100

`define BOOT_ADDR_RST   32'h1C00_0000
`define RESP_OKAY       2'd0
`define RESP_SLVERR     2'd2

`endif

/* rtl/cluster_periph_pkg.sv */
/*
 * AXI4-Lite request and response structs, the internal register
 * bus struct and the unit select type
 */
`include "cluster_periph_defines.svh"

package cluster_periph_pkg;

  // Driven by the AXI4-Lite master
  typedef struct packed {
    logic [`ADDR_W-1:0] aw_addr;
    logic               aw_valid;
    logic [`DATA_W-1:0] w_data;
    logic               w_valid;
    logic               b_ready;
    logic [`ADDR_W-1:0] ar_addr;
    logic               ar_valid;
    logic               r_ready;
  } axil_req_t;

  // Driven by the slave
  typedef struct packed {
    logic               aw_ready;
    logic               w_ready;
    logic               ar_ready;
    logic               b_valid;
    logic [1:0]         b_resp;
    logic               r_valid;
    logic [`DATA_W-1:0] r_data;
    logic [1:0]         r_resp;
  } axil_rsp_t;

  // Byte offset inside one unit
  typedef logic [`UNIT_SEL_LSB-1:0] reg_off_t;

  // Broadcast to every unit, qualified by a per-unit valid
  typedef struct packed {
    logic               we;
    reg_off_t           off;
    logic [`DATA_W-1:0] wdata;
  } reg_req_t;

  typedef enum logic [1:0] {
    SEL_CTRL     = `UNIT_CTRL,
    SEL_TIMER    = `UNIT_TIMER,
    SEL_EVENT    = `UNIT_EVENT,
    SEL_UNMAPPED = 2'd3
  } unit_sel_t;

endpackage

/* rtl/periph_axil_slave.sv */
/*
 * AXI4-Lite slave with one transaction in flight, unit decode
 * and the held B and R channels
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module periph_axil_slave
  import cluster_periph_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  axil_req_t          axil_req_i,
  output axil_rsp_t          axil_rsp_o,
  output reg_req_t           reg_req_o,
  output logic               ctrl_valid_o,
  output logic               timer_valid_o,
  output logic               eu_valid_o,
  input  logic [`DATA_W-1:0] ctrl_rdata_i,
  input  logic [`DATA_W-1:0] timer_rdata_i,
  input  logic [`DATA_W-1:0] eu_rdata_i
);

  logic               busy;
  logic               rd_acc;
  logic               wr_acc;
  logic [`ADDR_W-1:0] addr;
  unit_sel_t          sel;
  logic [`DATA_W-1:0] sel_rdata;
  logic               sel_err;

  logic               b_valid_q;
  logic [1:0]         b_resp_q;
  logic               r_valid_q;
  logic [1:0]         r_resp_q;
  logic [`DATA_W-1:0] r_data_q;

  // A held response blocks every new acceptance
  assign busy   = b_valid_q | r_valid_q;
  // Read wins when both are offered
  assign rd_acc = axil_req_i.ar_valid & ~busy;
  assign wr_acc = axil_req_i.aw_valid & axil_req_i.w_valid & ~busy & ~axil_req_i.ar_valid;

  assign addr = axil_req_i.ar_valid ? axil_req_i.ar_addr : axil_req_i.aw_addr;
  assign sel  = unit_sel_t'(addr[`ADDR_W-1:`UNIT_SEL_LSB]);

  assign reg_req_o.we    = wr_acc;
  assign reg_req_o.off   = addr[`UNIT_SEL_LSB-1:0];
  assign reg_req_o.wdata = axil_req_i.w_data;

  // ********************************************************************
  // Unit decode and read data select
  // ********************************************************************
  always_comb begin
    ctrl_valid_o  = 1'b0;
    timer_valid_o = 1'b0;
    eu_valid_o    = 1'b0;
    sel_rdata     = '0;
    sel_err       = 1'b0;
    case (sel)
      SEL_CTRL: begin
        ctrl_valid_o = rd_acc | wr_acc;
        sel_rdata    = ctrl_rdata_i;
      end
      SEL_TIMER: begin
        timer_valid_o = rd_acc | wr_acc;
        sel_rdata     = timer_rdata_i;
      end
      SEL_EVENT: begin
        eu_valid_o = rd_acc | wr_acc;
        sel_rdata  = eu_rdata_i;
      end
      default: sel_err = 1'b1;
    endcase
  end

  // ********************************************************************
  // Response channels
  // ********************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_acc) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_acc) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Payload captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      b_resp_q <= sel_err ? `RESP_SLVERR : `RESP_OKAY;
    end
    if (rd_acc) begin
      r_data_q <= sel_rdata;
      r_resp_q <= sel_err ? `RESP_SLVERR : `RESP_OKAY;
    end
  end

  assign axil_rsp_o.aw_ready = wr_acc;
  assign axil_rsp_o.w_ready  = wr_acc;
  assign axil_rsp_o.ar_ready = rd_acc;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.r_valid  = r_valid_q;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;

endmodule

/* rtl/cluster_control_unit.sv */
/*
 * End-of-computation, fetch-enable and boot-address registers
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module cluster_control_unit
  import cluster_periph_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  reg_req_t                          reg_req_i,
  output logic [`DATA_W-1:0]                rdata_o,
  output logic                              eoc_o,
  output logic [`NB_CORES-1:0]              fetch_enable_o,
  output logic [`NB_CORES-1:0][`DATA_W-1:0] boot_addr_o
);

  logic                              wr;
  logic                              eoc_q;
  logic [`NB_CORES-1:0]              fetch_en_q;
  logic [`NB_CORES-1:0][`DATA_W-1:0] boot_addr_q;
  logic [`NB_CORES-1:0]              boot_hit;

  assign wr = valid_i & reg_req_i.we;

  // One boot address word per core, packed from the base
  always_comb begin
    for (int i = 0; i < `NB_CORES; i++) begin
      boot_hit[i] = (reg_req_i.off == reg_off_t'(`CTRL_BOOT_BASE + 4 * i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= {`NB_CORES{`BOOT_ADDR_RST}};
    end else if (wr) begin
      if (reg_req_i.off == `CTRL_EOC) begin
        eoc_q <= reg_req_i.wdata[0];
      end
      if (reg_req_i.off == `CTRL_FETCH_EN) begin
        fetch_en_q <= reg_req_i.wdata[`NB_CORES-1:0];
      end
      for (int i = 0; i < `NB_CORES; i++) begin
        if (boot_hit[i]) begin
          boot_addr_q[i] <= reg_req_i.wdata;
        end
      end
    end
  end

  // Read back with zero for unknown offsets
  always_comb begin
    rdata_o = '0;
    if (reg_req_i.off == `CTRL_EOC) begin
      rdata_o = {{(`DATA_W-1){1'b0}}, eoc_q};
    end
    if (reg_req_i.off == `CTRL_FETCH_EN) begin
      rdata_o = {{(`DATA_W-`NB_CORES){1'b0}}, fetch_en_q};
    end
    for (int i = 0; i < `NB_CORES; i++) begin
      if (boot_hit[i]) begin
        rdata_o = boot_addr_q[i];
      end
    end
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

/* rtl/cluster_timer.sv */
/*
 * 32-bit timer with compare match and one-cycle event output
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  reg_req_t           reg_req_i,
  output logic [`DATA_W-1:0] rdata_o,
  output logic               timer_evt_o
);

  logic               wr;
  logic               match;
  logic [1:0]         cfg_q;
  logic [`DATA_W-1:0] count_q;
  logic [`DATA_W-1:0] cmp_q;
  logic               evt_q;

  assign wr = valid_i & reg_req_i.we;

  // cfg_q[0] enables counting, cfg_q[1] clears the counter on a match
  assign match = cfg_q[0] & (count_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q   <= '0;
      count_q <= '0;
      cmp_q   <= '0;
      evt_q   <= 1'b0;
    end else begin
      evt_q <= match;
      if (wr && reg_req_i.off == `TIMER_CFG) begin
        cfg_q <= reg_req_i.wdata[1:0];
      end
      if (wr && reg_req_i.off == `TIMER_CMP) begin
        cmp_q <= reg_req_i.wdata;
      end
      // Software load beats the increment
      if (wr && reg_req_i.off == `TIMER_COUNT) begin
        count_q <= reg_req_i.wdata;
      end else if (cfg_q[0]) begin
        if (match && cfg_q[1]) begin
          count_q <= '0;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (reg_req_i.off)
      `TIMER_CFG:   rdata_o = {{(`DATA_W-2){1'b0}}, cfg_q};
      `TIMER_COUNT: rdata_o = count_q;
      `TIMER_CMP:   rdata_o = cmp_q;
      default:      rdata_o = '0;
    endcase
  end

  assign timer_evt_o = evt_q;

endmodule

/* rtl/event_unit.sv */
/*
 * Per-core event buffers and masks, software events and the
 * interrupt request, identifier and acknowledge logic
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module event_unit
  import cluster_periph_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               valid_i,
  input  reg_req_t                           reg_req_i,
  output logic [`DATA_W-1:0]                 rdata_o,
  input  logic                               timer_evt_i,
  input  logic                               host_mailbox_irq_i,
  input  logic [`NB_CORES-1:0]               irq_ack_i,
  input  logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_ack_id_i,
  output logic [`NB_CORES-1:0]               irq_req_o,
  output logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_id_o
);

  logic                              wr;
  logic                              sw_wr;
  logic [`NB_CORES-1:0]              mask_hit;
  logic [`NB_CORES-1:0]              buf_hit;
  logic [`NB_CORES-1:0]              clr_hit;
  logic [`NB_CORES-1:0][`NB_EVT-1:0] evt_set;
  logic [`NB_CORES-1:0][`NB_EVT-1:0] evt_clr;
  logic [`NB_CORES-1:0][`NB_EVT-1:0] pending;
  logic [`NB_CORES-1:0][`NB_EVT-1:0] buffer_q;
  logic [`NB_CORES-1:0][`NB_EVT-1:0] mask_q;

  assign wr    = valid_i & reg_req_i.we;
  assign sw_wr = wr & (reg_req_i.off == `EU_SW_EVT);

  always_comb begin
    for (int i = 0; i < `NB_CORES; i++) begin
      mask_hit[i] = (reg_req_i.off == reg_off_t'(`EU_CORE_STRIDE * i + `EU_MASK));
      buf_hit[i]  = (reg_req_i.off == reg_off_t'(`EU_CORE_STRIDE * i + `EU_BUFFER));
      clr_hit[i]  = (reg_req_i.off == reg_off_t'(`EU_CORE_STRIDE * i + `EU_CLEAR));
      // Timer and mailbox go to every core, software events per core
      evt_set[i]               = '0;
      evt_set[i][`EVT_TIMER]   = timer_evt_i;
      evt_set[i][`EVT_MAILBOX] = host_mailbox_irq_i;
      evt_set[i][`EVT_SW]      = sw_wr & reg_req_i.wdata[i];
      evt_clr[i] = (wr && clr_hit[i]) ? reg_req_i.wdata[`NB_EVT-1:0] : '0;
      if (irq_ack_i[i]) begin
        evt_clr[i][irq_ack_id_i[i]] = 1'b1;
      end
      pending[i] = buffer_q[i] & mask_q[i];
    end
  end

  // A new event wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buffer_q <= '0;
      mask_q   <= '0;
    end else begin
      buffer_q <= (buffer_q & ~evt_clr) | evt_set;
      for (int i = 0; i < `NB_CORES; i++) begin
        if (wr && mask_hit[i]) begin
          mask_q[i] <= reg_req_i.wdata[`NB_EVT-1:0];
        end
      end
    end
  end

  // Lowest masked pending index names the interrupt
  always_comb begin
    for (int i = 0; i < `NB_CORES; i++) begin
      irq_req_o[i] = |pending[i];
      irq_id_o[i]  = '0;
      for (int j = `NB_EVT - 1; j >= 0; j--) begin
        if (pending[i][j]) begin
          irq_id_o[i] = `EVT_ID_W'(j);
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < `NB_CORES; i++) begin
      if (mask_hit[i]) begin
        rdata_o = {{(`DATA_W-`NB_EVT){1'b0}}, mask_q[i]};
      end
      if (buf_hit[i]) begin
        rdata_o = {{(`DATA_W-`NB_EVT){1'b0}}, buffer_q[i]};
      end
    end
  end

endmodule

/* rtl/cluster_peripherals.sv */
/*
 * Cluster peripheral block, AXI4-Lite slave wired to the control
 * unit, the timer and the event unit
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module cluster_peripherals
  import cluster_periph_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  axil_req_t                          axil_req_i,
  output axil_rsp_t                          axil_rsp_o,
  input  logic                               host_mailbox_irq_i,
  input  logic [`NB_CORES-1:0]               irq_ack_i,
  input  logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_ack_id_i,
  output logic                               eoc_o,
  output logic [`NB_CORES-1:0]               fetch_enable_o,
  output logic [`NB_CORES-1:0][`DATA_W-1:0]  boot_addr_o,
  output logic [`NB_CORES-1:0]               irq_req_o,
  output logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_id_o
);

  reg_req_t           reg_req;
  logic               ctrl_valid;
  logic               timer_valid;
  logic               eu_valid;
  logic [`DATA_W-1:0] ctrl_rdata;
  logic [`DATA_W-1:0] timer_rdata;
  logic [`DATA_W-1:0] eu_rdata;
  logic               timer_evt;

  // ********************************************************************
  // Bus slave
  // ********************************************************************
  periph_axil_slave periph_axil_slave_i (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .axil_req_i    ( axil_req_i  ),
    .axil_rsp_o    ( axil_rsp_o  ),
    .reg_req_o     ( reg_req     ),
    .ctrl_valid_o  ( ctrl_valid  ),
    .timer_valid_o ( timer_valid ),
    .eu_valid_o    ( eu_valid    ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .eu_rdata_i    ( eu_rdata    )
  );

  // ********************************************************************
  // Register units
  // ********************************************************************
  cluster_control_unit cluster_control_unit_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .valid_i        ( ctrl_valid     ),
    .reg_req_i      ( reg_req        ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer cluster_timer_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .valid_i     ( timer_valid ),
    .reg_req_i   ( reg_req     ),
    .rdata_o     ( timer_rdata ),
    .timer_evt_o ( timer_evt   )
  );

  event_unit event_unit_i (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .valid_i            ( eu_valid           ),
    .reg_req_i          ( reg_req            ),
    .rdata_o            ( eu_rdata           ),
    .timer_evt_i        ( timer_evt          ),
    .host_mailbox_irq_i ( host_mailbox_irq_i ),
    .irq_ack_i          ( irq_ack_i          ),
    .irq_ack_id_i       ( irq_ack_id_i       ),
    .irq_req_o          ( irq_req_o          ),
    .irq_id_o           ( irq_id_o           )
  );

endmodule

/* tests/cluster_peripherals_checker.sv */
/*
 * AXI4-Lite response, interrupt identifier and reset assertions,
 * bound to the cluster peripheral top level
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module cluster_peripherals_checker
  import cluster_periph_pkg::*;
(
  input logic                                clk_i,
  input logic                                rst_n_i,
  input axil_req_t                           axil_req_i,
  input axil_rsp_t                           axil_rsp_i,
  input logic                                eoc_i,
  input logic [`NB_CORES-1:0]                fetch_enable_i,
  input logic [`NB_CORES-1:0]                irq_req_i,
  input logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_id_i,
  input logic [`NB_CORES-1:0][`NB_EVT-1:0]   buffer_i,
  input logic [`NB_CORES-1:0][`NB_EVT-1:0]   mask_i
);

  // ********************************************************************
  // Response channels
  // ********************************************************************
  b_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.b_valid && !axil_req_i.b_ready |=> axil_rsp_i.b_valid)
    else $error("b_valid dropped before b_ready");

  r_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.r_valid && !axil_req_i.r_ready |=> axil_rsp_i.r_valid)
    else $error("r_valid dropped before r_ready");

  b_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.aw_ready |=> axil_rsp_i.b_valid)
    else $error("no write response one cycle after acceptance");

  b_only_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(axil_rsp_i.b_valid) |-> $past(axil_rsp_i.aw_ready && axil_rsp_i.w_ready))
    else $error("write response without an accepted write");

  r_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.ar_ready |=> axil_rsp_i.r_valid)
    else $error("no read response one cycle after acceptance");

  r_only_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(axil_rsp_i.r_valid) |-> $past(axil_rsp_i.ar_ready))
    else $error("read response without an accepted read");

  // ********************************************************************
  // Interrupt identifier
  // ********************************************************************
  // The id names the lowest masked pending event
  for (genvar i = 0; i < `NB_CORES; i++) begin : g_irq
    logic [`NB_EVT-1:0] pending;
    logic [`NB_EVT-1:0] below_id;

    assign pending  = buffer_i[i] & mask_i[i];
    assign below_id = (`NB_EVT'(1) << irq_id_i[i]) - `NB_EVT'(1);

    irq_id_lowest: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      irq_req_i[i] |-> pending[irq_id_i[i]] && ((pending & below_id) == '0))
      else $error("irq_id_o[%0d] is not the lowest masked pending event", i);
  end

  reset_outputs_low: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !eoc_i && fetch_enable_i == '0 && irq_req_i == '0 &&
      !axil_rsp_i.aw_ready && !axil_rsp_i.w_ready && !axil_rsp_i.ar_ready &&
      !axil_rsp_i.b_valid && !axil_rsp_i.r_valid)
    else $error("control output high in the cycle after reset release");

endmodule

bind cluster_peripherals cluster_peripherals_checker periph_checker_i (
  .clk_i          ( clk_i                 ),
  .rst_n_i        ( rst_n_i               ),
  .axil_req_i     ( axil_req_i            ),
  .axil_rsp_i     ( axil_rsp_o            ),
  .eoc_i          ( eoc_o                 ),
  .fetch_enable_i ( fetch_enable_o        ),
  .irq_req_i      ( irq_req_o             ),
  .irq_id_i       ( irq_id_o              ),
  .buffer_i       ( event_unit_i.buffer_q ),
  .mask_i         ( event_unit_i.mask_q   )
);

/* tests/tb_cluster_peripherals.sv */
/*
 * Testbench for the cluster peripheral block with AXI4-Lite driver
 * tasks, a register model, directed and random stimulus and a timeout
 */
`timescale 1ns/10ps
`include "cluster_periph_defines.svh"

module tb_cluster_peripherals
  import cluster_periph_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 3000;

  logic                                clk;
  logic                                rst_n;
  axil_req_t                           axil_req;
  axil_rsp_t                           axil_rsp;
  logic                                host_mailbox_irq;
  logic [`NB_CORES-1:0]                irq_ack;
  logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_ack_id;
  logic                                eoc;
  logic [`NB_CORES-1:0]                fetch_enable;
  logic [`NB_CORES-1:0][`DATA_W-1:0]   boot_addr;
  logic [`NB_CORES-1:0]                irq_req;
  logic [`NB_CORES-1:0][`EVT_ID_W-1:0] irq_id;

  // Register model
  logic [`DATA_W-1:0]                  model_boot [`NB_CORES];
  logic [`NB_CORES-1:0]                model_fetch;
  logic                                model_eoc;
  logic [`NB_EVT-1:0]                  model_buf  [`NB_CORES];
  logic [`NB_EVT-1:0]                  model_mask [`NB_CORES];

  logic [31:0]                         rng_state;
  int                                  cycles = 0;

  cluster_peripherals dut (
    .clk_i              ( clk              ),
    .rst_n_i            ( rst_n            ),
    .axil_req_i         ( axil_req         ),
    .axil_rsp_o         ( axil_rsp         ),
    .host_mailbox_irq_i ( host_mailbox_irq ),
    .irq_ack_i          ( irq_ack          ),
    .irq_ack_id_i       ( irq_ack_id       ),
    .eoc_o              ( eoc              ),
    .fetch_enable_o     ( fetch_enable     ),
    .boot_addr_o        ( boot_addr        ),
    .irq_req_o          ( irq_req          ),
    .irq_id_o           ( irq_id           )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, the tests did not finish", cycles));
    end
  end

  // ********************************************************************
  // Helpers
  // ********************************************************************
  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  function automatic logic [`ADDR_W-1:0] reg_addr(input logic [1:0] unit, input reg_off_t off);
    return {unit, off};
  endfunction

  function automatic reg_off_t boot_off(input int core);
    return reg_off_t'(`CTRL_BOOT_BASE + 4 * core);
  endfunction

  function automatic reg_off_t eu_off(input int core, input reg_off_t off);
    return reg_off_t'(`EU_CORE_STRIDE * core + off);
  endfunction

  function automatic logic [31:0] lowest_index(input logic [`NB_EVT-1:0] bits);
    for (int j = 0; j < `NB_EVT; j++) begin
      if (bits[j]) begin
        return 32'(j);
      end
    end
    return 32'd0;
  endfunction

  // ********************************************************************
  // AXI4-Lite master
  // ********************************************************************
  task automatic axil_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
                            output logic [1:0] resp);
    int delay;
    delay = int'(next_random() % 4);
    @(negedge clk);
    axil_req.aw_addr  = addr;
    axil_req.aw_valid = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_valid  = 1'b1;
    // Nothing is pending here, so b_valid marks the acceptance
    @(negedge clk);
    while (!axil_rsp.b_valid) @(negedge clk);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    resp = axil_rsp.b_resp;
    repeat (delay) @(negedge clk);
    axil_req.b_ready = 1'b1;
    @(negedge clk);
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data,
                           output logic [1:0] resp);
    int delay;
    delay = int'(next_random() % 4);
    @(negedge clk);
    axil_req.ar_addr  = addr;
    axil_req.ar_valid = 1'b1;
    @(negedge clk);
    while (!axil_rsp.r_valid) @(negedge clk);
    axil_req.ar_valid = 1'b0;
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    repeat (delay) @(negedge clk);
    axil_req.r_ready = 1'b1;
    @(negedge clk);
    axil_req.r_ready = 1'b0;
  endtask

  task automatic write_reg(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_value("b_resp", 32'(`RESP_OKAY), 32'(resp));
  endtask

  task automatic read_word(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_value("r_resp", 32'(`RESP_OKAY), 32'(resp));
  endtask

  task automatic read_expect(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] exp,
                             input string name);
    logic [`DATA_W-1:0] data;
    read_word(addr, data);
    check_value(name, exp, data);
  endtask

  // ********************************************************************
  // Model comparisons
  // ********************************************************************
  task automatic check_ctrl();
    for (int i = 0; i < `NB_CORES; i++) begin
      read_expect(reg_addr(`UNIT_CTRL, boot_off(i)), model_boot[i],
                  $sformatf("boot_addr[%0d]", i));
      check_value($sformatf("boot_addr_o[%0d]", i), model_boot[i], boot_addr[i]);
    end
    read_expect(reg_addr(`UNIT_CTRL, `CTRL_FETCH_EN), 32'(model_fetch), "CTRL_FETCH_EN");
    check_value("fetch_enable_o", 32'(model_fetch), 32'(fetch_enable));
    read_expect(reg_addr(`UNIT_CTRL, `CTRL_EOC), 32'(model_eoc), "CTRL_EOC");
    check_value("eoc_o", 32'(model_eoc), 32'(eoc));
  endtask

  // Request when any masked event is pending and the id names the lowest one
  task automatic check_irq();
    logic [`NB_EVT-1:0] pend;
    for (int i = 0; i < `NB_CORES; i++) begin
      pend = model_buf[i] & model_mask[i];
      check_value($sformatf("irq_req_o[%0d]", i), 32'(|pend), 32'(irq_req[i]));
      if (|pend) begin
        check_value($sformatf("irq_id_o[%0d]", i), lowest_index(pend), 32'(irq_id[i]));
      end
    end
  endtask

  task automatic check_buffers();
    for (int i = 0; i < `NB_CORES; i++) begin
      read_expect(reg_addr(`UNIT_EVENT, eu_off(i, `EU_BUFFER)), 32'(model_buf[i]),
                  $sformatf("EU_BUFFER[%0d]", i));
    end
  endtask

  task automatic check_count_bound();
    logic [`DATA_W-1:0] count;
    read_word(reg_addr(`UNIT_TIMER, `TIMER_COUNT), count);
    assert (count <= 32'd20) else begin
      abort_run($sformatf("ERR %0t TIMER_COUNT expected <= %h actual %h",
                          $time, 32'd20, count));
    end
  endtask

  // ********************************************************************
  // Tests
  // ********************************************************************
  task automatic test_ctrl_regs();
    check_ctrl();
    for (int i = 0; i < `NB_CORES; i++) begin
      model_boot[i] = next_random();
      write_reg(reg_addr(`UNIT_CTRL, boot_off(i)), model_boot[i]);
    end
    model_fetch = `NB_CORES'(next_random());
    write_reg(reg_addr(`UNIT_CTRL, `CTRL_FETCH_EN), 32'(model_fetch));
    model_eoc = 1'b1;
    write_reg(reg_addr(`UNIT_CTRL, `CTRL_EOC), 32'(model_eoc));
    check_ctrl();
  endtask

  task automatic test_unmapped();
    logic [`DATA_W-1:0] data;
    logic [1:0]         resp;
    axil_read(reg_addr(2'd3, `CTRL_EOC), data, resp);
    check_value("r_resp", 32'(`RESP_SLVERR), 32'(resp));
    check_value("r_data", 32'd0, data);
    axil_write(reg_addr(2'd3, boot_off(0)), 32'hDEAD_BEEF, resp);
    check_value("b_resp", 32'(`RESP_SLVERR), 32'(resp));
    // Unknown offsets inside the mapped units
    write_reg(reg_addr(`UNIT_CTRL, 10'h3FC), 32'hFFFF_FFFF);
    read_expect(reg_addr(`UNIT_CTRL, 10'h3FC), 32'd0, "ctrl unknown offset");
    read_expect(reg_addr(`UNIT_TIMER, 10'h00C), 32'd0, "timer unknown offset");
    read_expect(reg_addr(`UNIT_EVENT, 10'h200), 32'd0, "event unknown offset");
    check_ctrl();
  endtask

  task automatic test_backpressure();
    int core;
    for (int n = 0; n < 8; n++) begin
      core = int'(next_random() % `NB_CORES);
      model_boot[core] = next_random();
      write_reg(reg_addr(`UNIT_CTRL, boot_off(core)), model_boot[core]);
      read_expect(reg_addr(`UNIT_CTRL, boot_off(core)), model_boot[core],
                  $sformatf("boot_addr[%0d]", core));
    end
  endtask

  task automatic test_timer();
    logic [`DATA_W-1:0] buf0;
    write_reg(reg_addr(`UNIT_TIMER, `TIMER_CMP), 32'd20);
    write_reg(reg_addr(`UNIT_TIMER, `TIMER_CFG), 32'h3);
    buf0 = '0;
    // Poll until the match reaches core 0
    while (!buf0[`EVT_TIMER]) begin
      check_count_bound();
      read_word(reg_addr(`UNIT_EVENT, eu_off(0, `EU_BUFFER)), buf0);
    end
    // Reads past the match see the counter wrap to zero
    repeat (8) check_count_bound();
    for (int i = 0; i < `NB_CORES; i++) begin
      model_buf[i][`EVT_TIMER] = 1'b1;
    end
    check_buffers();
    write_reg(reg_addr(`UNIT_TIMER, `TIMER_CFG), 32'h0);
  endtask

  task automatic clear_buffers();
    for (int i = 0; i < `NB_CORES; i++) begin
      write_reg(reg_addr(`UNIT_EVENT, eu_off(i, `EU_CLEAR)), 32'hF);
      model_buf[i] = '0;
    end
    check_buffers();
    check_irq();
  endtask

  task automatic ack_round();
    logic [`NB_EVT-1:0] pend;
    @(negedge clk);
    for (int i = 0; i < `NB_CORES; i++) begin
      pend = model_buf[i] & model_mask[i];
      irq_ack[i]    = |pend;
      irq_ack_id[i] = `EVT_ID_W'(lowest_index(pend));
      if (|pend) begin
        model_buf[i][lowest_index(pend)] = 1'b0;
      end
    end
    @(negedge clk);
    irq_ack = '0;
    check_irq();
  endtask

  task automatic test_irq();
    clear_buffers();
    // Mailbox and software events unmasked on a subset of cores
    model_mask[0] = 4'b0110;
    model_mask[1] = 4'b0010;
    model_mask[2] = 4'b0100;
    model_mask[3] = 4'b0000;
    for (int i = 0; i < `NB_CORES; i++) begin
      write_reg(reg_addr(`UNIT_EVENT, eu_off(i, `EU_MASK)), 32'(model_mask[i]));
      read_expect(reg_addr(`UNIT_EVENT, eu_off(i, `EU_MASK)), 32'(model_mask[i]),
                  $sformatf("EU_MASK[%0d]", i));
    end
    check_irq();
    @(negedge clk);
    host_mailbox_irq = 1'b1;
    @(negedge clk);
    host_mailbox_irq = 1'b0;
    for (int i = 0; i < `NB_CORES; i++) begin
      model_buf[i][`EVT_MAILBOX] = 1'b1;
    end
    write_reg(reg_addr(`UNIT_EVENT, `EU_SW_EVT), 32'b0101);
    model_buf[0][`EVT_SW] = 1'b1;
    model_buf[2][`EVT_SW] = 1'b1;
    check_irq();
    check_buffers();
    repeat (3) ack_round();
    check_buffers();
    clear_buffers();
  endtask

  initial begin : stimulus
    rng_state        = 32'd5250;
    axil_req         = '0;
    rst_n            = 1'b0;
    host_mailbox_irq = 1'b0;
    irq_ack          = '0;
    irq_ack_id       = '0;
    model_fetch      = '0;
    model_eoc        = 1'b0;
    for (int i = 0; i < `NB_CORES; i++) begin
      model_boot[i] = `BOOT_ADDR_RST;
      model_buf[i]  = '0;
      model_mask[i] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_ctrl_regs();
    test_unmapped();
    test_backpressure();
    test_timer();
    test_irq();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* list.f */
+incdir+rtl
rtl/cluster_periph_pkg.sv
rtl/periph_axil_slave.sv
rtl/cluster_control_unit.sv
rtl/cluster_timer.sv
rtl/event_unit.sv
rtl/cluster_peripherals.sv
tests/cluster_peripherals_checker.sv
tests/tb_cluster_peripherals.sv

/* Makefile */
TOP := tb_cluster_peripherals

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
